// ==== flist.f ====
verilog/cache_axi_pkg.sv
verilog/line_collector.sv
verilog/line_serializer.sv
verilog/cache_axi_bridge.sv
verilog/axi_burst_memory.sv
verilog/cache_mem_top.sv
sim/tb_cache_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cache_mem_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_cache_mem_top.sv ====
`timescale 1ns/1ps

module tb_cache_mem_top;

    import cache_axi_pkg::*;

    localparam int CLK_HALF        = 5;
    localparam int IDX_W           = $clog2(MEM_WORDS);
    localparam int LINE_BYTES      = LINE_W / 8;
    localparam int N_LINES         = MEM_WORDS / LINE_BEATS;    // 64 lines
    localparam int N_IC            = 60;
    localparam int N_DC            = 60;
    localparam int N_WR            = 60;
    localparam int N_PAIR          = 30;
    localparam int N_OVL           = 30;
    localparam int INIT_OPS        = 2 * N_LINES;
    localparam int TEST_OPS        = 400;
    localparam int WATCHDOG_CYCLES = TEST_OPS * 60 + INIT_OPS * 40;

    logic              aclk;
    logic              aresetn;
    logic [ADDR_W-1:0] i_ic_raddr;
    logic [LEN_W-1:0]  i_ic_rlen;
    logic              i_ic_rvalid;
    logic [LINE_W-1:0] o_ic_rdata;
    logic              o_ic_rready;
    logic [ADDR_W-1:0] i_dc_raddr;
    logic [LEN_W-1:0]  i_dc_rlen;
    logic              i_dc_rvalid;
    logic [LINE_W-1:0] o_dc_rdata;
    logic              o_dc_rready;
    logic [ADDR_W-1:0] i_dc_waddr;
    logic [LINE_W-1:0] i_dc_wdata;
    logic [LEN_W-1:0]  i_dc_wlen;
    logic [STRB_W-1:0] i_dc_wstrb;
    logic              i_dc_wvalid;
    logic              o_dc_wready;

    logic [BEAT_W-1:0] model_mem [MEM_WORDS];           // reference copy of the memory
    int                mismatch_errors;
    int                other_errors;

    cache_mem_top cache_mem_top_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_ic_raddr  (i_ic_raddr),
        .i_ic_rlen   (i_ic_rlen),
        .i_ic_rvalid (i_ic_rvalid),
        .o_ic_rdata  (o_ic_rdata),
        .o_ic_rready (o_ic_rready),
        .i_dc_raddr  (i_dc_raddr),
        .i_dc_rlen   (i_dc_rlen),
        .i_dc_rvalid (i_dc_rvalid),
        .o_dc_rdata  (o_dc_rdata),
        .o_dc_rready (o_dc_rready),
        .i_dc_waddr  (i_dc_waddr),
        .i_dc_wdata  (i_dc_wdata),
        .i_dc_wlen   (i_dc_wlen),
        .i_dc_wstrb  (i_dc_wstrb),
        .i_dc_wvalid (i_dc_wvalid),
        .o_dc_wready (o_dc_wready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] line;
        line = '0;
        for (int k = 0; k < LINE_BEATS; k++)
        begin
            line = {line[LINE_W-BEAT_W-1:0], $urandom};
        end
        return line;
    endfunction

    // last beat ends on top, earlier beats below it, zeros beneath
    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr,
                                                        input int len);
        logic [LINE_W-1:0] line;
        logic [IDX_W-1:0]  widx;
        line = '0;
        widx = IDX_W'(addr >> 2);
        for (int k = 0; k <= len; k++)
        begin
            line[(LINE_BEATS - 1 - len + k) * BEAT_W +: BEAT_W] = model_mem[widx];
            widx = widx + IDX_W'(1);
        end
        return line;
    endfunction

    task automatic apply_write_to_model(input logic [ADDR_W-1:0] addr,
                                        input logic [LINE_W-1:0] data,
                                        input int len,
                                        input logic [STRB_W-1:0] strb);
        logic [LINE_W-1:0] shifted;
        logic [STRB_W-1:0] lanes;
        logic [BEAT_W-1:0] mask;
        logic [IDX_W-1:0]  widx;
        int                ofs;
        ofs     = int'(addr[1:0]);                      // byte offset within a beat
        shifted = data << (8 * ofs);
        lanes   = strb << ofs;                          // upper lanes drop off
        mask    = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        widx    = IDX_W'(addr >> 2);
        for (int k = 0; k <= len; k++)
        begin
            model_mem[widx] = (model_mem[widx] & ~mask) | (shifted[BEAT_W-1:0] & mask);
            shifted = shifted >> BEAT_W;
            widx    = widx + IDX_W'(1);
        end
    endtask

    task automatic check_line(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            mismatch_errors++;
            $display("mismatch at %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_dcache(input logic [ADDR_W-1:0] addr, input int len,
                               output logic [LINE_W-1:0] line, output time t);
        @(posedge aclk);
        #1;
        i_dc_raddr  = addr;
        i_dc_rlen   = LEN_W'(len);
        i_dc_rvalid = 1'b1;
        @(negedge aclk);
        while (!o_dc_rready)
        begin
            @(negedge aclk);
        end
        line = o_dc_rdata;                              // only valid during the pulse
        t    = $time;
        @(posedge aclk);
        #1;
        i_dc_rvalid = 1'b0;
    endtask

    task automatic read_icache(input logic [ADDR_W-1:0] addr, input int len,
                               output logic [LINE_W-1:0] line, output time t);
        @(posedge aclk);
        #1;
        i_ic_raddr  = addr;
        i_ic_rlen   = LEN_W'(len);
        i_ic_rvalid = 1'b1;
        @(negedge aclk);
        while (!o_ic_rready)
        begin
            @(negedge aclk);
        end
        line = o_ic_rdata;
        t    = $time;
        @(posedge aclk);
        #1;
        i_ic_rvalid = 1'b0;
    endtask

    task automatic write_dcache(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data,
                                input int len, input logic [STRB_W-1:0] strb);
        @(posedge aclk);
        #1;
        i_dc_waddr  = addr;
        i_dc_wdata  = data;
        i_dc_wlen   = LEN_W'(len);
        i_dc_wstrb  = strb;
        i_dc_wvalid = 1'b1;
        @(negedge aclk);
        while (!o_dc_wready)
        begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        i_dc_wvalid = 1'b0;
    endtask

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] raddr;
        logic [LINE_W-1:0] data;
        logic [LINE_W-1:0] got;
        logic [LINE_W-1:0] got_ic;
        logic [LINE_W-1:0] exp_ic;
        logic [STRB_W-1:0] strb;
        time               t_dc;
        time               t_ic;
        int                wline;
        int                rline;
        int                len;
        int                word;
        int                ofs;

        void'($urandom(32'hfd6d));
        mismatch_errors = 0;
        other_errors    = 0;
        aresetn     = 1'b0;
        i_ic_raddr  = '0;
        i_ic_rlen   = '0;
        i_ic_rvalid = 1'b0;
        i_dc_raddr  = '0;
        i_dc_rlen   = '0;
        i_dc_rvalid = 1'b0;
        i_dc_waddr  = '0;
        i_dc_wdata  = '0;
        i_dc_wlen   = '0;
        i_dc_wstrb  = '0;
        i_dc_wvalid = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        if (o_ic_rready || o_dc_rready || o_dc_wready)
        begin
            other_errors++;
            $display("a cache ready pulse was high right after reset at %0t", $time);
        end

        // fill every line, then read it all back
        for (int n = 0; n < N_LINES; n++)
        begin
            addr = ADDR_W'(n * LINE_BYTES);
            data = random_line();
            write_dcache(addr, data, LINE_BEATS - 1, '1);
            apply_write_to_model(addr, data, LINE_BEATS - 1, '1);
        end
        for (int n = 0; n < N_LINES; n++)
        begin
            addr = ADDR_W'(n * LINE_BYTES);
            read_dcache(addr, LINE_BEATS - 1, got, t_dc);
            check_line(got, expected_line(addr, LINE_BEATS - 1), $sformatf("init line %0d", n));
        end

        for (int n = 0; n < N_IC; n++)
        begin
            addr = ADDR_W'(int'($urandom % N_LINES) * LINE_BYTES);
            read_icache(addr, LINE_BEATS - 1, got, t_ic);
            check_line(got, expected_line(addr, LINE_BEATS - 1), "icache line read");
        end

        // partial bursts anywhere inside a line
        for (int n = 0; n < N_DC; n++)
        begin
            len  = int'($urandom % LINE_BEATS);
            word = int'($urandom % (LINE_BEATS - len));
            addr = ADDR_W'(int'($urandom % N_LINES) * LINE_BYTES + word * STRB_W);
            read_dcache(addr, len, got, t_dc);
            check_line(got, expected_line(addr, len), $sformatf("dcache read len %0d", len));
        end

        for (int n = 0; n < N_WR; n++)
        begin
            wline = int'($urandom % N_LINES);
            len   = int'($urandom % LINE_BEATS);
            word  = int'($urandom % (LINE_BEATS - len));
            ofs   = int'($urandom % STRB_W);
            strb  = STRB_W'($urandom);
            data  = random_line();
            addr  = ADDR_W'(wline * LINE_BYTES + word * STRB_W + ofs);
            write_dcache(addr, data, len, strb);
            apply_write_to_model(addr, data, len, strb);
            addr = ADDR_W'(wline * LINE_BYTES);
            read_dcache(addr, LINE_BEATS - 1, got, t_dc);
            check_line(got, expected_line(addr, LINE_BEATS - 1),
                       $sformatf("readback after write ofs %0d strb %h", ofs, strb));
        end

        // both read ports raised on the same cycle
        for (int n = 0; n < N_PAIR; n++)
        begin
            len   = int'($urandom % LINE_BEATS);
            addr  = ADDR_W'(int'($urandom % N_LINES) * LINE_BYTES);
            raddr = ADDR_W'(int'($urandom % N_LINES) * LINE_BYTES);
            fork
                read_dcache(addr, len, got, t_dc);
                read_icache(raddr, LINE_BEATS - 1, got_ic, t_ic);
            join
            check_line(got, expected_line(addr, len), "dcache read racing icache");
            check_line(got_ic, expected_line(raddr, LINE_BEATS - 1), "icache read racing dcache");
            if (t_dc >= t_ic)
            begin
                other_errors++;
                $display("data cache was not served first: dcache ready at %0t, icache at %0t",
                         t_dc, t_ic);
            end
        end

        // write on one line while the icache reads another
        for (int n = 0; n < N_OVL; n++)
        begin
            wline  = int'($urandom % N_LINES);
            rline  = (wline + 1 + int'($urandom % (N_LINES - 1))) % N_LINES;
            len    = int'($urandom % LINE_BEATS);
            ofs    = int'($urandom % STRB_W);
            strb   = STRB_W'($urandom);
            data   = random_line();
            addr   = ADDR_W'(wline * LINE_BYTES + ofs);
            raddr  = ADDR_W'(rline * LINE_BYTES);
            exp_ic = expected_line(raddr, LINE_BEATS - 1);
            fork
                write_dcache(addr, data, len, strb);
                read_icache(raddr, LINE_BEATS - 1, got_ic, t_ic);
            join
            check_line(got_ic, exp_ic, "icache read during write");
            apply_write_to_model(addr, data, len, strb);
            addr = ADDR_W'(wline * LINE_BYTES);
            read_dcache(addr, LINE_BEATS - 1, got, t_dc);
            check_line(got, expected_line(addr, LINE_BEATS - 1), "readback of overlapped write");
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if ((mismatch_errors == 0) && (other_errors == 0))
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog/cache_mem_top.sv ====
`timescale 1ns/1ps

module cache_mem_top (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_ic_raddr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_ic_rlen,
    input  logic                             i_ic_rvalid,
    output logic [cache_axi_pkg::LINE_W-1:0] o_ic_rdata,
    output logic                             o_ic_rready,
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_dc_raddr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_dc_rlen,
    input  logic                             i_dc_rvalid,
    output logic [cache_axi_pkg::LINE_W-1:0] o_dc_rdata,
    output logic                             o_dc_rready,
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_dc_waddr,
    input  logic [cache_axi_pkg::LINE_W-1:0] i_dc_wdata,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_dc_wlen,
    input  logic [cache_axi_pkg::STRB_W-1:0] i_dc_wstrb,
    input  logic                             i_dc_wvalid,
    output logic                             o_dc_wready
);

    import cache_axi_pkg::*;

    // axi4 between bridge and memory, always size word and burst incr
    logic [ADDR_W-1:0] ar_addr;
    logic [LEN_W-1:0]  ar_len;
    logic              ar_valid;
    logic              ar_ready;
    logic [BEAT_W-1:0] r_data;
    logic              r_last;
    logic              r_valid;
    logic              r_ready;
    logic [ADDR_W-1:0] aw_addr;
    logic [LEN_W-1:0]  aw_len;
    logic              aw_valid;
    logic              aw_ready;
    logic [BEAT_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic              w_last;
    logic              w_valid;
    logic              w_ready;
    logic              b_valid;
    logic              b_ready;

    cache_axi_bridge bridge_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_ic_raddr  (i_ic_raddr),
        .i_ic_rlen   (i_ic_rlen),
        .i_ic_rvalid (i_ic_rvalid),
        .o_ic_rdata  (o_ic_rdata),
        .o_ic_rready (o_ic_rready),
        .i_dc_raddr  (i_dc_raddr),
        .i_dc_rlen   (i_dc_rlen),
        .i_dc_rvalid (i_dc_rvalid),
        .o_dc_rdata  (o_dc_rdata),
        .o_dc_rready (o_dc_rready),
        .i_dc_waddr  (i_dc_waddr),
        .i_dc_wdata  (i_dc_wdata),
        .i_dc_wlen   (i_dc_wlen),
        .i_dc_wstrb  (i_dc_wstrb),
        .i_dc_wvalid (i_dc_wvalid),
        .o_dc_wready (o_dc_wready),
        .o_ar_addr   (ar_addr),
        .o_ar_len    (ar_len),
        .o_ar_valid  (ar_valid),
        .i_ar_ready  (ar_ready),
        .i_r_data    (r_data),
        .i_r_last    (r_last),
        .i_r_valid   (r_valid),
        .o_r_ready   (r_ready),
        .o_aw_addr   (aw_addr),
        .o_aw_len    (aw_len),
        .o_aw_valid  (aw_valid),
        .i_aw_ready  (aw_ready),
        .o_w_data    (w_data),
        .o_w_strb    (w_strb),
        .o_w_last    (w_last),
        .o_w_valid   (w_valid),
        .i_w_ready   (w_ready),
        .i_b_valid   (b_valid),
        .o_b_ready   (b_ready)
    );

    axi_burst_memory memory_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar_addr  (ar_addr),
        .i_ar_len   (ar_len),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r_data   (r_data),
        .o_r_last   (r_last),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .i_aw_addr  (aw_addr),
        .i_aw_len   (aw_len),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_w_data   (w_data),
        .i_w_strb   (w_strb),
        .i_w_last   (w_last),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready)
    );

endmodule

// ==== verilog/axi_burst_memory.sv ====
`timescale 1ns/1ps

module axi_burst_memory (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_ar_addr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_ar_len,
    input  logic                             i_ar_valid,
    output logic                             o_ar_ready,
    output logic [cache_axi_pkg::BEAT_W-1:0] o_r_data,
    output logic                             o_r_last,
    output logic                             o_r_valid,
    input  logic                             i_r_ready,
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_aw_addr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_aw_len,
    input  logic                             i_aw_valid,
    output logic                             o_aw_ready,
    input  logic [cache_axi_pkg::BEAT_W-1:0] i_w_data,
    input  logic [cache_axi_pkg::STRB_W-1:0] i_w_strb,
    input  logic                             i_w_last,
    input  logic                             i_w_valid,
    output logic                             o_w_ready,
    output logic                             o_b_valid,
    input  logic                             i_b_ready
);

    import cache_axi_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int IDX_LO = AXI_SIZE_WORD;           // word index starts above byte offset

    logic [BEAT_W-1:0] mem [MEM_WORDS];
    logic [1:0]        state;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic [LEN_W-1:0]  rd_cnt;
    logic [LEN_W-1:0]  rd_len;
    logic [LEN_W-1:0]  wr_cnt;
    logic [LEN_W-1:0]  wr_len;
    logic              r_hs;
    logic              w_hs;

    // write wins when both address channels are pending
    assign o_aw_ready = (state == MEM_IDLE);
    assign o_ar_ready = (state == MEM_IDLE) & ~i_aw_valid;
    assign o_r_valid  = (state == MEM_READ);
    assign o_w_ready  = (state == MEM_WRITE);
    assign o_b_valid  = (state == MEM_RESP);
    assign o_r_data   = mem[rd_idx];
    assign o_r_last   = o_r_valid & (rd_cnt == rd_len);
    assign r_hs       = o_r_valid & i_r_ready;
    assign w_hs       = o_w_ready & i_w_valid;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state  <= MEM_IDLE;
            rd_idx <= '0;
            rd_cnt <= '0;
            rd_len <= '0;
            wr_idx <= '0;
            wr_cnt <= '0;
            wr_len <= '0;
        end
        else
        begin
            case (state)
                MEM_IDLE:
                begin
                    if (i_aw_valid)
                    begin
                        state  <= MEM_WRITE;
                        wr_idx <= i_aw_addr[IDX_LO +: IDX_W];
                        wr_cnt <= '0;
                        wr_len <= i_aw_len;
                    end
                    else if (i_ar_valid)
                    begin
                        state  <= MEM_READ;
                        rd_idx <= i_ar_addr[IDX_LO +: IDX_W];
                        rd_cnt <= '0;
                        rd_len <= i_ar_len;
                    end
                end
                MEM_READ:
                begin
                    if (r_hs)
                    begin
                        rd_idx <= rd_idx + 1'b1;
                        rd_cnt <= rd_cnt + 1'b1;
                        if (o_r_last)
                        begin
                            state <= MEM_IDLE;
                        end
                    end
                end
                MEM_WRITE:
                begin
                    if (w_hs)
                    begin
                        wr_idx <= wr_idx + 1'b1;
                        wr_cnt <= wr_cnt + 1'b1;
                        if (i_w_last || (wr_cnt == wr_len))
                        begin
                            state <= MEM_RESP;      // b_valid next cycle
                        end
                    end
                end
                default:
                begin
                    if (i_b_ready)
                    begin
                        state <= MEM_IDLE;
                    end
                end
            endcase
        end
    end

    // byte lanes follow the strobe
    always_ff @(posedge aclk)
    begin
        if (w_hs)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (i_w_strb[b])
                begin
                    mem[wr_idx][b*8 +: 8] <= i_w_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== verilog/cache_axi_bridge.sv ====
`timescale 1ns/1ps

module cache_axi_bridge (
    input  logic                             aclk,
    input  logic                             aresetn,

    // instruction cache read
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_ic_raddr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_ic_rlen,
    input  logic                             i_ic_rvalid,
    output logic [cache_axi_pkg::LINE_W-1:0] o_ic_rdata,
    output logic                             o_ic_rready,

    // data cache read
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_dc_raddr,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_dc_rlen,
    input  logic                             i_dc_rvalid,
    output logic [cache_axi_pkg::LINE_W-1:0] o_dc_rdata,
    output logic                             o_dc_rready,

    // data cache write
    input  logic [cache_axi_pkg::ADDR_W-1:0] i_dc_waddr,
    input  logic [cache_axi_pkg::LINE_W-1:0] i_dc_wdata,
    input  logic [cache_axi_pkg::LEN_W-1:0]  i_dc_wlen,
    input  logic [cache_axi_pkg::STRB_W-1:0] i_dc_wstrb,
    input  logic                             i_dc_wvalid,
    output logic                             o_dc_wready,

    // axi4 master
    output logic [cache_axi_pkg::ADDR_W-1:0] o_ar_addr,
    output logic [cache_axi_pkg::LEN_W-1:0]  o_ar_len,
    output logic                             o_ar_valid,
    input  logic                             i_ar_ready,
    input  logic [cache_axi_pkg::BEAT_W-1:0] i_r_data,
    input  logic                             i_r_last,
    input  logic                             i_r_valid,
    output logic                             o_r_ready,
    output logic [cache_axi_pkg::ADDR_W-1:0] o_aw_addr,
    output logic [cache_axi_pkg::LEN_W-1:0]  o_aw_len,
    output logic                             o_aw_valid,
    input  logic                             i_aw_ready,
    output logic [cache_axi_pkg::BEAT_W-1:0] o_w_data,
    output logic [cache_axi_pkg::STRB_W-1:0] o_w_strb,
    output logic                             o_w_last,
    output logic                             o_w_valid,
    input  logic                             i_w_ready,
    input  logic                             i_b_valid,
    output logic                             o_b_ready
);

    import cache_axi_pkg::*;

    localparam int OFS_W = AXI_SIZE_WORD;            // byte offset bits within a beat

    logic [2:0]                      rd_state;
    logic [2:0]                      rd_next;
    logic                            r_hs;
    logic                            r_done;
    logic [(LINE_BEATS-1)*BEAT_W-1:0] rd_low;
    logic [LINE_W-1:0]               rd_line;

    logic [1:0]                      wr_state;
    logic [1:0]                      wr_next;
    logic [LEN_W-1:0]                w_cnt;
    logic                            w_hs;
    logic [OFS_W-1:0]                w_ofs;
    logic [LINE_W-1:0]               w_line_sh;

    // read path
    assign o_r_ready = (rd_state == RD_IDATA) || (rd_state == RD_DDATA);
    assign r_hs      = i_r_valid & o_r_ready;
    assign r_done    = r_hs & i_r_last;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            rd_state <= RD_IDLE;
        end
        else
        begin
            rd_state <= rd_next;
        end
    end

    always_comb
    begin
        rd_next    = rd_state;
        o_ar_valid = 1'b0;
        o_ar_addr  = i_dc_raddr;
        o_ar_len   = i_dc_rlen;
        case (rd_state)
            RD_IDLE:
            begin
                if (i_dc_rvalid)                     // data cache always wins
                begin
                    o_ar_valid = 1'b1;
                    rd_next    = i_ar_ready ? RD_DDATA : RD_DADDR;
                end
                else if (i_ic_rvalid)
                begin
                    o_ar_valid = 1'b1;
                    o_ar_addr  = i_ic_raddr;
                    o_ar_len   = i_ic_rlen;
                    rd_next    = i_ar_ready ? RD_IDATA : RD_IADDR;
                end
            end
            RD_IADDR:
            begin
                o_ar_valid = 1'b1;
                o_ar_addr  = i_ic_raddr;
                o_ar_len   = i_ic_rlen;
                if (i_ar_ready)
                begin
                    rd_next = RD_IDATA;
                end
            end
            RD_DADDR:
            begin
                o_ar_valid = 1'b1;
                if (i_ar_ready)
                begin
                    rd_next = RD_DDATA;
                end
            end
            RD_IDATA, RD_DDATA:
            begin
                if (r_done)
                begin
                    rd_next = RD_IDLE;
                end
            end
            default:
            begin
                rd_next = RD_IDLE;
            end
        endcase
    end

    line_collector collector_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_shift    (r_hs),
        .i_flush    (r_done),
        .i_beat     (i_r_data),
        .o_line_low (rd_low)
    );

    assign rd_line     = {i_r_data, rd_low};        // live last beat on top
    assign o_ic_rready = r_done & (rd_state == RD_IDATA);
    assign o_dc_rready = r_done & (rd_state == RD_DDATA);
    assign o_ic_rdata  = o_ic_rready ? rd_line : '0;
    assign o_dc_rdata  = o_dc_rready ? rd_line : '0;

    // write path
    assign w_ofs     = i_dc_waddr[OFS_W-1:0];
    assign w_line_sh = i_dc_wdata << {w_ofs, 3'b000};
    assign o_w_strb  = i_dc_wstrb << w_ofs;
    assign o_aw_addr = i_dc_waddr;
    assign o_aw_len  = i_dc_wlen;

    assign o_aw_valid  = (wr_state == WR_ADDR);
    assign o_w_valid   = (wr_state == WR_DATA);
    assign o_b_ready   = (wr_state == WR_RESP);
    assign w_hs        = o_w_valid & i_w_ready;
    assign o_w_last    = o_w_valid & (w_cnt == i_dc_wlen);
    assign o_dc_wready = w_hs & o_w_last;

    always_comb
    begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE:
            begin
                if (i_dc_wvalid)
                begin
                    wr_next = WR_ADDR;
                end
            end
            WR_ADDR:
            begin
                if (i_aw_ready)
                begin
                    wr_next = WR_DATA;
                end
            end
            WR_DATA:
            begin
                if (o_dc_wready)
                begin
                    wr_next = WR_RESP;
                end
            end
            default:
            begin
                if (i_b_valid)
                begin
                    wr_next = WR_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            wr_state <= WR_IDLE;
            w_cnt    <= '0;
        end
        else
        begin
            wr_state <= wr_next;
            if (wr_state == WR_ADDR)
            begin
                w_cnt <= '0;
            end
            else if (w_hs)
            begin
                w_cnt <= w_cnt + 1'b1;               // handshakes only, not bare ready
            end
        end
    end

    line_serializer serializer_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    ((wr_state == WR_IDLE) & i_dc_wvalid),
        .i_line    (w_line_sh),
        .i_advance (w_hs),
        .o_beat    (o_w_data)
    );

endmodule

// ==== verilog/line_serializer.sv ====
`timescale 1ns/1ps

module line_serializer (
    input  logic                             aclk,
    input  logic                             aresetn,
    input  logic                             i_load,     // capture shifted write line
    input  logic [cache_axi_pkg::LINE_W-1:0] i_line,
    input  logic                             i_advance,  // w beat accepted
    output logic [cache_axi_pkg::BEAT_W-1:0] o_beat
);

    import cache_axi_pkg::*;

    logic [LINE_W-1:0] line_q;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (i_load)
        begin
            line_q <= i_line;
        end
        else if (i_advance)
        begin
            line_q <= {{BEAT_W{1'b0}}, line_q[LINE_W-1:BEAT_W]};  // next word to bottom
        end
    end

    // current beat is always the low word
    assign o_beat = line_q[BEAT_W-1:0];

endmodule

// ==== verilog/line_collector.sv ====
`timescale 1ns/1ps

module line_collector (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic                                 i_shift,    // one r beat accepted
    input  logic                                 i_flush,    // final beat of the burst
    input  logic [cache_axi_pkg::BEAT_W-1:0]     i_beat,
    output logic [(cache_axi_pkg::LINE_BEATS-1)*cache_axi_pkg::BEAT_W-1:0] o_line_low
);

    import cache_axi_pkg::*;

    localparam int LOW_W = (LINE_BEATS - 1) * BEAT_W;

    logic [LOW_W-1:0] line_q;

    // newest beat enters at the top, older beats drift down one word
    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (i_flush)
        begin
            line_q <= '0;                            // next burst starts from zero
        end
        else if (i_shift)
        begin
            line_q <= {i_beat, line_q[LOW_W-1:BEAT_W]};
        end
    end

    assign o_line_low = line_q;

endmodule

// ==== verilog/cache_axi_pkg.sv ====
package cache_axi_pkg;

    // line and beat geometry
    localparam int BEAT_W     = 32;
    localparam int LINE_W     = 512;
    localparam int LINE_BEATS = LINE_W / BEAT_W;   // 16 beats per line
    localparam int ADDR_W     = 32;
    localparam int LEN_W      = 8;                 // axi4 burst length field
    localparam int STRB_W     = BEAT_W / 8;

    // burst memory depth in words
    localparam int MEM_WORDS  = 1024;

    // fixed burst attributes
    localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;  // 4 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    // bridge read FSM
    localparam logic [2:0] RD_IDLE  = 3'd0;
    localparam logic [2:0] RD_IADDR = 3'd1;
    localparam logic [2:0] RD_IDATA = 3'd2;
    localparam logic [2:0] RD_DADDR = 3'd3;
    localparam logic [2:0] RD_DDATA = 3'd4;

    // bridge write FSM
    localparam logic [1:0] WR_IDLE = 2'd0;
    localparam logic [1:0] WR_ADDR = 2'd1;
    localparam logic [1:0] WR_DATA = 2'd2;
    localparam logic [1:0] WR_RESP = 2'd3;

    // memory channel FSM
    localparam logic [1:0] MEM_IDLE  = 2'd0;
    localparam logic [1:0] MEM_READ  = 2'd1;
    localparam logic [1:0] MEM_WRITE = 2'd2;
    localparam logic [1:0] MEM_RESP  = 2'd3;

endpackage
